// File: files.f
source/pfpu_pkg.sv
source/pfpu_prog_ram.sv
source/pfpu_prog.sv
source/pfpu_seq.sv
source/pfpu_wb_ctl.sv
source/pfpu_prog_top.sv
testbench/pfpu_prog_assert.sv
testbench/tb_pfpu_prog.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the program store testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_pfpu_prog -o sim_tb
# The log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: source/pfpu_pkg.sv
// ------------------------------------------------
// Sizes, register map and bus structs of the program store
// Page and offset widths must add up to the program address width
// ------------------------------------------------
package pfpu_pkg;

  // ------------------------------------------------
  // Program memory geometry
  // ------------------------------------------------
  localparam int PROG_AW    = 11;
  localparam int PROG_DW    = 25;
  localparam int PROG_WORDS = 1 << PROG_AW;
  // Last program address, end of a full run
  localparam logic [PROG_AW-1:0] PROG_LAST = PROG_AW'(PROG_WORDS - 1);

  // Host window split
  localparam int PAGE_W = 2;
  localparam int OFFS_W = 9;

  // ------------------------------------------------
  // Instruction fields
  // ------------------------------------------------
  localparam int REG_AW = 7;
  localparam int OPC_W  = 4;
  localparam logic [OPC_W-1:0] OP_HALT = 4'hF;

  // ------------------------------------------------
  // Wishbone and register map
  // ------------------------------------------------
  localparam int WB_AW = 12;
  localparam int WB_DW = 32;
  // Top word address bit selects the program window
  localparam int WIN_BIT = WB_AW - 1;
  localparam logic [WB_AW-1:0] ADR_CTL   = 12'd0;
  localparam logic [WB_AW-1:0] ADR_PAGE  = 12'd1;
  localparam logic [WB_AW-1:0] ADR_COUNT = 12'd2;

  // MSB first, 7 + 7 + 4 + 7 bits
  typedef struct packed {
    logic [REG_AW-1:0] a_addr;
    logic [REG_AW-1:0] b_addr;
    logic [OPC_W-1:0]  opcode;
    logic [REG_AW-1:0] w_addr;
  } pfpu_instr_t;

  // Host side of the classic bus
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  // Host access into program memory
  typedef struct packed {
    logic              c_en;
    logic              c_w_en;
    logic [PAGE_W-1:0] c_page;
    logic [OFFS_W-1:0] c_offset;
    logic [WB_DW-1:0]  c_di;
  } prog_acc_t;

endpackage

// File: source/pfpu_prog.sv
// ------------------------------------------------
// Fetch counter, host address mux and field decode
// Host access owns the RAM port whenever c_en is high
// ------------------------------------------------
`timescale 1ns/1ps

module pfpu_prog (
  input  logic                         sys_clk,
  input  logic                         arst_n,
  input  logic                         count_rst,
  input  pfpu_pkg::prog_acc_t          acc,
  output logic [pfpu_pkg::WB_DW-1:0]   c_do,
  output logic [pfpu_pkg::PROG_AW-1:0] pc,
  output pfpu_pkg::pfpu_instr_t        instr
);
  import pfpu_pkg::*;

  logic [PROG_AW-1:0] counter;
  logic [PROG_AW-1:0] mem_a;
  logic               mem_we;
  logic [PROG_DW-1:0] mem_di;
  logic [PROG_DW-1:0] mem_do;

  // ------------------------------------------------
  // Fetch counter
  // ------------------------------------------------
  // Held at 0 between runs, wraps after the last word
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      counter <= '0;
    end else if (count_rst) begin
      counter <= '0;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  assign pc = counter;

  // ------------------------------------------------
  // RAM port
  // ------------------------------------------------
  // Host page and offset form the full word address
  assign mem_a  = acc.c_en ? {acc.c_page, acc.c_offset} : counter;
  assign mem_we = acc.c_en & acc.c_w_en;
  // Upper bus bits are dropped
  assign mem_di = acc.c_di[PROG_DW-1:0];

  pfpu_prog_ram u_ram (
    .sys_clk (sys_clk),
    .a       (mem_a),
    .we      (mem_we),
    .di      (mem_di),
    .do_     (mem_do)
  );

  // Zero padded word back to the host
  assign c_do = {{(WB_DW - PROG_DW){1'b0}}, mem_do};

  // Field split follows the struct layout
  assign instr = pfpu_instr_t'(mem_do);

endmodule

// File: source/pfpu_prog_ram.sv
// ------------------------------------------------
// Single port program store, read data one cycle after address
// Write cycle returns the old word, content undefined after reset
// ------------------------------------------------
`timescale 1ns/1ps

module pfpu_prog_ram (
  input  logic                         sys_clk,
  input  logic [pfpu_pkg::PROG_AW-1:0] a,
  input  logic                         we,
  input  logic [pfpu_pkg::PROG_DW-1:0] di,
  output logic [pfpu_pkg::PROG_DW-1:0] do_
);
  import pfpu_pkg::*;

  // Program word storage
  logic [PROG_DW-1:0] mem [0:PROG_WORDS-1];

  // Read first behaviour
  always_ff @(posedge sys_clk) begin
    if (we) begin
      mem[a] <= di;
    end
    do_ <= mem[a];
  end

endmodule

// File: source/pfpu_prog_top.sv
// ------------------------------------------------
// Program store top, host bus in, decoded instruction stream out
// ------------------------------------------------
`timescale 1ns/1ps

module pfpu_prog_top (
  input  logic                  sys_clk,
  input  logic                  arst_n,
  input  pfpu_pkg::wb_req_t     wb_req,
  output pfpu_pkg::wb_rsp_t     wb_rsp,
  output pfpu_pkg::pfpu_instr_t instr,
  output logic                  instr_valid,
  output logic                  busy
);
  import pfpu_pkg::*;

  prog_acc_t          acc;
  logic [WB_DW-1:0]   c_do;
  logic [PROG_AW-1:0] pc;
  logic [PROG_AW:0]   issue_count;
  logic               start;
  logic               count_rst;

  // Host bus and control registers
  pfpu_wb_ctl u_wb_ctl (
    .sys_clk     (sys_clk),
    .arst_n      (arst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .acc         (acc),
    .c_do        (c_do),
    .start       (start),
    .busy        (busy),
    .issue_count (issue_count)
  );

  // Program memory and fetch
  pfpu_prog u_prog (
    .sys_clk   (sys_clk),
    .arst_n    (arst_n),
    .count_rst (count_rst),
    .acc       (acc),
    .c_do      (c_do),
    .pc        (pc),
    .instr     (instr)
  );

  // Run control
  pfpu_seq u_seq (
    .sys_clk     (sys_clk),
    .arst_n      (arst_n),
    .start       (start),
    .instr       (instr),
    .pc          (pc),
    .count_rst   (count_rst),
    .busy        (busy),
    .instr_valid (instr_valid),
    .issue_count (issue_count)
  );

endmodule

// File: source/pfpu_seq.sv
// ------------------------------------------------
// Run control, one instruction issued per cycle from address 0
// Start is ignored while a run is in progress
// ------------------------------------------------
`timescale 1ns/1ps

module pfpu_seq (
  input  logic                         sys_clk,
  input  logic                         arst_n,
  input  logic                         start,
  input  pfpu_pkg::pfpu_instr_t        instr,
  input  logic [pfpu_pkg::PROG_AW-1:0] pc,
  output logic                         count_rst,
  output logic                         busy,
  output logic                         instr_valid,
  output logic [pfpu_pkg::PROG_AW:0]   issue_count
);
  import pfpu_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_RUN
  } state_t;

  state_t             state;
  // Address of the word now on instr
  logic [PROG_AW-1:0] pc_d;
  logic               is_halt;
  logic               is_last;
  logic               run_end;

  // ------------------------------------------------
  // End of run detection
  // ------------------------------------------------
  assign is_halt = (instr.opcode == OP_HALT);
  assign is_last = (pc_d == PROG_LAST);
  // Ending word is still issued
  assign run_end = instr_valid & (is_halt | is_last);

  assign busy = (state == S_RUN);

  // RAM read is one cycle behind the counter
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_d <= '0;
    end else begin
      pc_d <= pc;
    end
  end

  // ------------------------------------------------
  // Run FSM and issue count
  // ------------------------------------------------
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= S_IDLE;
      count_rst   <= 1'b1;
      instr_valid <= 1'b0;
      issue_count <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          instr_valid <= 1'b0;
          // Counter released together with busy
          if (start) begin
            state       <= S_RUN;
            count_rst   <= 1'b0;
            issue_count <= '0;
          end
        end
        default: begin
          if (run_end) begin
            state       <= S_IDLE;
            count_rst   <= 1'b1;
            instr_valid <= 1'b0;
          end else begin
            // First word is readable one cycle into the run
            instr_valid <= 1'b1;
          end
          // Count every valid cycle, last one included
          if (instr_valid) begin
            issue_count <= issue_count + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

// File: source/pfpu_wb_ctl.sv
// ------------------------------------------------
// Wishbone classic slave, one wait state for registers, two for window
// Window accesses stall without ack until the current run is over
// ------------------------------------------------
`timescale 1ns/1ps

module pfpu_wb_ctl (
  input  logic                       sys_clk,
  input  logic                       arst_n,
  input  pfpu_pkg::wb_req_t          wb_req,
  output pfpu_pkg::wb_rsp_t          wb_rsp,
  output pfpu_pkg::prog_acc_t        acc,
  input  logic [pfpu_pkg::WB_DW-1:0] c_do,
  output logic                       start,
  input  logic                       busy,
  input  logic [pfpu_pkg::PROG_AW:0] issue_count
);
  import pfpu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_ACC,
    S_ACK
  } state_t;

  state_t            state;
  logic [PAGE_W-1:0] page_q;
  // Register read data, presented with ack
  logic [WB_DW-1:0]  rdat_q;
  logic              req;
  logic              win_sel;

  assign req     = wb_req.cyc & wb_req.stb;
  assign win_sel = wb_req.adr[WIN_BIT];

  // ------------------------------------------------
  // Access sequencing
  // ------------------------------------------------
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= S_IDLE;
      page_q <= '0;
      start  <= 1'b0;
    end else begin
      // Start is a single cycle pulse
      start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (req) begin
            if (win_sel) begin
              // Hold off the RAM port during a run
              state <= busy ? S_WAIT : S_ACC;
            end else begin
              state <= S_ACK;
              if (wb_req.we && wb_req.adr == ADR_CTL) begin
                start <= wb_req.dat[0];
              end
              if (wb_req.we && wb_req.adr == ADR_PAGE) begin
                page_q <= wb_req.dat[PAGE_W-1:0];
              end
            end
          end
        end
        S_WAIT: begin
          if (!busy) begin
            state <= S_ACC;
          end
        end
        S_ACC: begin
          state <= S_ACK;
        end
        default: begin
          // Master drops stb or presents a new request next
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Register read mux, captured with the request
  always_ff @(posedge sys_clk) begin
    if (state == S_IDLE && req && !win_sel) begin
      case (wb_req.adr)
        ADR_CTL:   rdat_q <= {{(WB_DW - 1){1'b0}}, busy};
        ADR_PAGE:  rdat_q <= {{(WB_DW - PAGE_W){1'b0}}, page_q};
        ADR_COUNT: rdat_q <= {{(WB_DW - PROG_AW - 1){1'b0}}, issue_count};
        default:   rdat_q <= '0;
      endcase
    end
  end

  // ------------------------------------------------
  // Program port and bus response
  // ------------------------------------------------
  always_comb begin
    // One RAM cycle per window access
    acc.c_en     = (state == S_ACC);
    acc.c_w_en   = wb_req.we;
    acc.c_page   = page_q;
    acc.c_offset = wb_req.adr[OFFS_W-1:0];
    acc.c_di     = wb_req.dat;
  end

  always_comb begin
    wb_rsp.ack = (state == S_ACK);
    // RAM output is valid in the ack cycle, request still steady
    wb_rsp.dat = win_sel ? c_do : rdat_q;
  end

endmodule

// File: testbench/pfpu_prog_assert.sv
// ------------------------------------------------
// Fetch counter and RAM port rules of pfpu_prog, checked after reset
// ------------------------------------------------
`timescale 1ns/1ps

module pfpu_prog_assert (
  input logic                         sys_clk,
  input logic                         arst_n,
  input logic                         count_rst,
  input pfpu_pkg::prog_acc_t          acc,
  input logic [pfpu_pkg::WB_DW-1:0]   c_do,
  input logic [pfpu_pkg::PROG_AW-1:0] pc,
  input pfpu_pkg::pfpu_instr_t        instr,
  input logic [pfpu_pkg::PROG_AW-1:0] counter,
  input logic [pfpu_pkg::PROG_AW-1:0] mem_a,
  input logic                         mem_we,
  input logic [pfpu_pkg::PROG_DW-1:0] mem_do
);
  import pfpu_pkg::*;

  // ------------------------------------------------
  // Counter
  // ------------------------------------------------
  a_count_clr: assert property (@(posedge sys_clk) disable iff (!arst_n)
    count_rst |=> counter == '0)
    else $error("counter not cleared by count_rst");

  // Wraps after the last word
  a_count_inc: assert property (@(posedge sys_clk) disable iff (!arst_n)
    !count_rst |=> counter == PROG_AW'($past(counter) + 1'b1))
    else $error("counter did not step by one");

  a_pc: assert property (@(posedge sys_clk) disable iff (!arst_n) pc == counter)
    else $error("pc differs from counter");

  // ------------------------------------------------
  // RAM port
  // ------------------------------------------------
  a_mux_host: assert property (@(posedge sys_clk) disable iff (!arst_n)
    acc.c_en |-> mem_a == {acc.c_page, acc.c_offset})
    else $error("host address not on RAM port");

  a_mux_fetch: assert property (@(posedge sys_clk) disable iff (!arst_n)
    !acc.c_en |-> mem_a == counter)
    else $error("counter not on RAM port");

  a_we: assert property (@(posedge sys_clk) disable iff (!arst_n)
    mem_we == (acc.c_en & acc.c_w_en))
    else $error("RAM write enable mismatch");

  a_pad: assert property (@(posedge sys_clk) disable iff (!arst_n)
    c_do[WB_DW-1:PROG_DW] == '0)
    else $error("c_do upper bits not zero");

  a_decode: assert property (@(posedge sys_clk) disable iff (!arst_n) instr === mem_do)
    else $error("instr differs from RAM read data");

endmodule

bind pfpu_prog pfpu_prog_assert u_prog_assert (
  .sys_clk   (sys_clk),
  .arst_n    (arst_n),
  .count_rst (count_rst),
  .acc       (acc),
  .c_do      (c_do),
  .pc        (pc),
  .instr     (instr),
  .counter   (counter),
  .mem_a     (mem_a),
  .mem_we    (mem_we),
  .mem_do    (mem_do)
);

// File: testbench/pfpu_prog_cases.txt
# W addr word : program image word in hex, written through the window
# R addr : readback check, N page count : random words at offsets 0 to count-1
W 000 01234567
W 001 fe00a1b2
W 002 00155a5a
W 003 01ffff00
W 03f 00c0fe0e
W 040 00082f83
W 041 01555555
W 200 00abcdef
W 3ff 01000001
W 600 ffffe0ff
W 7ff 1bad1dea
N 2 40
R 000
R 001
R 003
R 040
R 123
R 3ff
R 555
R 600
R 7ff

// File: testbench/tb_pfpu_prog.sv
// ------------------------------------------------
// Reads testbench/pfpu_prog_cases.txt relative to the project root
// Stops at the first mismatch
// ------------------------------------------------
`timescale 1ns/1ps

module tb_pfpu_prog;
  import pfpu_pkg::*;

  logic        sys_clk;
  logic        arst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  pfpu_instr_t instr;
  logic        instr_valid;
  logic        busy;

  // Reference image of the stored 25 bit words
  logic [PROG_DW-1:0] model [0:PROG_WORDS-1];
  logic [PROG_AW-1:0] img_addr [$];
  logic [WB_DW-1:0]   img_word [$];
  logic [PROG_AW-1:0] rb_addr [$];
  logic [PAGE_W-1:0]  scratch_page;
  int                 scratch_n;
  logic [PAGE_W-1:0]  cur_page;
  logic [31:0]        rng_state;
  pfpu_instr_t        stream_q [$];
  int                 wd_limit;

  pfpu_prog_top uut (
    .sys_clk     (sys_clk),
    .arst_n      (arst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .instr       (instr),
    .instr_valid (instr_valid),
    .busy        (busy)
  );

  // 8 ns period
  always #4 sys_clk = ~sys_clk;

  // Stream items sampled mid cycle
  always @(negedge sys_clk) begin
    if (arst_n && instr_valid) begin
      stream_q.push_back(instr);
    end
  end

  // Watchdog starts once the case list sets its limit
  initial begin
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge sys_clk);
    stop_with_failure("watchdog expired before the tests completed");
  end

  // ------------------------------------------------
  // Reporting and compare
  // ------------------------------------------------
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [WB_DW-1:0] exp,
                            input logic [WB_DW-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_instr(input string name, input pfpu_instr_t exp,
                             input pfpu_instr_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input logic [PROG_AW:0] exp,
                             input logic [PROG_AW:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Fill word with opcode MSB clear and junk in bus bits 31:25
  function automatic logic [WB_DW-1:0] fill_word(input logic [PROG_AW-1:0] a);
    return {7'h55, a[6:0], ~a[6:0], 1'b0, a[10:8], a[7:1]};
  endfunction

  // Bus view of a stored word with zero upper bits
  function automatic logic [WB_DW-1:0] expected_word(input logic [PROG_AW-1:0] a);
    return WB_DW'(model[a]);
  endfunction

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [31:0] v1;
    logic [31:0] v2;
    fd = $fopen("testbench/pfpu_prog_cases.txt", "r");
    if (fd == 0) begin
      stop_with_failure("cannot open testbench/pfpu_prog_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        kind = line.getc(0);
        v2 = '0;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", v1, v2);
        case (kind)
          "W": begin
            img_addr.push_back(v1[PROG_AW-1:0]);
            img_word.push_back(v2);
          end
          "R": rb_addr.push_back(v1[PROG_AW-1:0]);
          "N": begin
            scratch_page = v1[PAGE_W-1:0];
            scratch_n    = int'(v2);
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Called on a falling edge and returns one idle cycle after ack
  task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [WB_DW-1:0] wdat, input int max_wait,
                            output logic [WB_DW-1:0] rdat, output int cycles);
    cycles = 0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do begin
      @(negedge sys_clk);
      cycles = cycles + 1;
      if (cycles > max_wait) begin
        stop_with_failure($sformatf("Wishbone timeout, no ack within %0d cycles", max_wait));
      end
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    wb_req = '0;
    @(negedge sys_clk);
  endtask

  task automatic reg_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
    logic [WB_DW-1:0] rd;
    int               cyc;
    bus_access(1'b1, adr, dat, 20, rd, cyc);
    if (cyc != 1) begin
      stop_with_failure("register write was not acked after one cycle");
    end
  endtask

  task automatic reg_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rd);
    int cyc;
    bus_access(1'b0, adr, '0, 20, rd, cyc);
    if (cyc != 1) begin
      stop_with_failure("register read was not acked after one cycle");
    end
  endtask

  // Page register follows the target address
  task automatic win_access(input logic we, input logic [PROG_AW-1:0] addr,
                            input logic [WB_DW-1:0] wdat, input int max_wait,
                            output logic [WB_DW-1:0] rdat, output int cycles);
    if (addr[PROG_AW-1 -: PAGE_W] != cur_page) begin
      reg_write(ADR_PAGE, WB_DW'(addr[PROG_AW-1 -: PAGE_W]));
      cur_page = addr[PROG_AW-1 -: PAGE_W];
    end
    bus_access(we, {1'b1, {(WB_AW - 1 - OFFS_W){1'b0}}, addr[OFFS_W-1:0]}, wdat,
               max_wait, rdat, cycles);
  endtask

  task automatic win_write(input logic [PROG_AW-1:0] addr, input logic [WB_DW-1:0] dat);
    logic [WB_DW-1:0] rd;
    int               cyc;
    win_access(1'b1, addr, dat, 20, rd, cyc);
    if (cyc != 2) begin
      stop_with_failure("window write was not acked after two cycles");
    end
    model[addr] = dat[PROG_DW-1:0];
  endtask

  task automatic win_read(input logic [PROG_AW-1:0] addr, output logic [WB_DW-1:0] rd);
    int cyc;
    win_access(1'b0, addr, '0, 20, rd, cyc);
    if (cyc != 2) begin
      stop_with_failure("window read was not acked after two cycles");
    end
  endtask

  task automatic wait_busy(input logic level, input int max_wait);
    int n;
    n = 0;
    while (busy !== level) begin
      @(negedge sys_clk);
      n = n + 1;
      if (n > max_wait && level) begin
        stop_with_failure("run did not start after a start write");
      end else if (n > max_wait) begin
        stop_with_failure("run never dropped busy");
      end
    end
  endtask

  task automatic start_run();
    stream_q.delete();
    reg_write(ADR_CTL, 32'h1);
    wait_busy(1'b1, 4);
  endtask

  // Stream must hold words 0 to n-1 in order
  task automatic check_stream(input int n);
    pfpu_instr_t exp;
    check_count("stream length", (PROG_AW + 1)'(n), (PROG_AW + 1)'(stream_q.size()));
    for (int i = 0; i < n; i++) begin
      exp = model[i];
      check_instr($sformatf("instr[%0d]", i), exp, stream_q[i]);
    end
  endtask

  // ------------------------------------------------
  // Test steps
  // ------------------------------------------------
  task automatic test_registers();
    logic [WB_DW-1:0] rd;
    reg_read(ADR_CTL, rd);
    check_word("CTL", 32'h0, rd);
    reg_read(ADR_PAGE, rd);
    check_word("PAGE", 32'h0, rd);
    reg_read(ADR_COUNT, rd);
    check_word("COUNT", 32'h0, rd);
    reg_write(ADR_PAGE, 32'h3);
    cur_page = 2'd3;
    reg_read(ADR_PAGE, rd);
    check_word("PAGE", 32'h3, rd);
  endtask

  task automatic load_program();
    logic [PROG_AW-1:0] a;
    // Whole memory gets a known word first
    for (int i = 0; i < PROG_WORDS; i++) begin
      a = PROG_AW'(i);
      win_write(a, fill_word(a));
    end
    for (int i = 0; i < img_addr.size(); i++) begin
      win_write(img_addr[i], img_word[i]);
    end
    // Random scratch words without a halt opcode
    for (int i = 0; i < scratch_n; i++) begin
      rng_state = xorshift32(rng_state);
      a = {scratch_page, OFFS_W'(i)};
      win_write(a, rng_state & ~32'h0000_0400);
      rb_addr.push_back(a);
    end
  endtask

  task automatic check_readback();
    logic [WB_DW-1:0] rd;
    for (int i = 0; i < rb_addr.size(); i++) begin
      win_read(rb_addr[i], rd);
      check_word($sformatf("wb_rsp.dat at %h", rb_addr[i]), expected_word(rb_addr[i]), rd);
    end
  endtask

  task automatic halt_run();
    pfpu_instr_t      ins;
    logic [WB_DW-1:0] rd;
    int               h;
    h = -1;
    // Lowest halt address wins
    for (int i = PROG_WORDS - 1; i >= 0; i--) begin
      ins = model[i];
      if (ins.opcode == OP_HALT) begin
        h = i;
      end
    end
    if (h < 0) begin
      stop_with_failure("program image holds no halt word");
    end
    start_run();
    wait_busy(1'b0, PROG_WORDS + 16);
    check_stream(h + 1);
    reg_read(ADR_COUNT, rd);
    check_count("COUNT", (PROG_AW + 1)'(h + 1), rd[PROG_AW:0]);
  endtask

  task automatic full_run();
    pfpu_instr_t        ins;
    logic [WB_DW-1:0]   rd;
    logic [PROG_AW-1:0] a;
    int                 cyc;
    // Halt words lose their opcode MSB
    for (int i = 0; i < PROG_WORDS; i++) begin
      ins = model[i];
      if (ins.opcode == OP_HALT) begin
        win_write(PROG_AW'(i), WB_DW'(model[i]) & ~32'h0000_0400);
      end
    end
    start_run();
    // Start while busy must be dropped
    reg_write(ADR_CTL, 32'h1);
    if (!busy) begin
      stop_with_failure("run ended before the stalled window read was issued");
    end
    a = PROG_LAST;
    win_access(1'b0, a, '0, PROG_WORDS + 64, rd, cyc);
    if (busy) begin
      stop_with_failure("window read was acked while a run was busy");
    end
    if (cyc <= 2) begin
      stop_with_failure("window read was not held off during the run");
    end
    check_word("wb_rsp.dat", expected_word(a), rd);
    check_stream(PROG_WORDS);
    reg_read(ADR_COUNT, rd);
    check_count("COUNT", (PROG_AW + 1)'(PROG_WORDS), rd[PROG_AW:0]);
    repeat (4) @(negedge sys_clk);
    if (busy) begin
      stop_with_failure("start written during the run began a second run");
    end
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    sys_clk      = 1'b0;
    arst_n       = 1'b0;
    wb_req       = '0;
    cur_page     = '0;
    scratch_page = '0;
    scratch_n    = 0;
    rng_state    = 32'h50f8_78ca;
    read_cases();
    // About 6 cycles per bus operation plus two full runs
    wd_limit = 6 * (PROG_WORDS + img_addr.size() + rb_addr.size() + 2 * scratch_n + 32)
             + 2 * (PROG_WORDS + 64) + 100;
    repeat (8) @(negedge sys_clk);
    arst_n = 1'b1;
    @(negedge sys_clk);
    test_registers();
    load_program();
    check_readback();
    halt_run();
    full_run();
    $display("*** PASSED ***");
    $finish;
  end

endmodule
